// ==== include/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath sizes
`define DATA_W    16
`define REG_COUNT 16
`define REG_AW    4
`define FLAG_W    5

// Immediate lives in the low instruction byte
`define IMM_W     8

// opExt codes under the REG opcode
`define EXT_AND   4'd1
`define EXT_OR    4'd2
`define EXT_XOR   4'd3
`define EXT_ADD   4'd5
`define EXT_SUB   4'd9
`define EXT_CMP   4'd11
`define EXT_MOV   4'd13

// opExt codes under the MEM opcode
`define EXT_LOAD  4'd0
`define EXT_STOR  4'd4
`define EXT_JCOND 4'd12

`endif

// ==== hdl/cpu_pkg.sv ====
`include "cpu_consts.svh"

package cpu_pkg;

	// Upper nibble of the instruction word
	typedef enum logic [3:0]
	{
		REG   = 4'd0,
		ANDI  = 4'd1,
		ORI   = 4'd2,
		XORI  = 4'd3,
		MEM   = 4'd4, // load, stor, jcond
		ADDI  = 4'd5,
		ADDUI = 4'd6,
		SUBI  = 4'd9,
		CMPI  = 4'd11,
		MOVI  = 4'd13,
		LUI   = 4'd15
	} opcode_e;

	typedef enum logic [2:0]
	{
		AND, OR, XOR, ADD, SUB, CMP, MOV, PASSUPPER
	} aluOp_e;

	// Condition code sits in the rDest field of a jcond
	typedef enum logic [3:0]
	{
		EQ = 4'd0,
		NE = 4'd1,
		LT = 4'd6,
		GT = 4'd12,
		UC = 4'd14 // Always taken
	} jumpCond_e;

	typedef struct packed
	{
		logic carry;
		logic low;      // Unsigned less
		logic overflow;
		logic zero;
		logic negative; // Signed less
	} flags_t;

	typedef struct packed
	{
		opcode_e             opcode;
		logic [`REG_AW-1:0] rDest;
		logic [`REG_AW-1:0] opExt;
		logic [`REG_AW-1:0] rSrc;
	} instFields_t;

	typedef struct packed
	{
		aluOp_e    aluOp;
		logic      useImm;     // Operand B from immediate
		logic      zeroExtend;
		logic      regWrite;
		logic      flagWrite;
		logic      memRead;
		logic      memWrite;
		logic      isJump;
		jumpCond_e jumpCond;
	} decodeCtrl_t;

endpackage

// ==== hdl/instDecoder.sv ====
`include "cpu_consts.svh"

module instDecoder import cpu_pkg::*;
(
	input  instFields_t        instIn,
	output decodeCtrl_t        ctrl,
	output logic [`DATA_W-1:0] imm
);

	logic [`IMM_W-1:0] immRaw;
	logic              aluValid; // Opcode maps to a real ALU op
	logic              isMem;
	aluOp_e            op;

	assign immRaw = {instIn.opExt, instIn.rSrc};
	assign isMem  = (instIn.opcode == MEM);

	//////////////////////////////////////////////////////////////////////
	// ALU operation select
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		aluValid = 1'b1;
		op       = AND;
		case (instIn.opcode)
			REG:
			begin
				case (instIn.opExt)
					`EXT_AND: op = AND;
					`EXT_OR:  op = OR;
					`EXT_XOR: op = XOR;
					`EXT_ADD: op = ADD;
					`EXT_SUB: op = SUB;
					`EXT_CMP: op = CMP;
					`EXT_MOV: op = MOV;
					default:  aluValid = 1'b0; // Unused ext, nop
				endcase
			end
			ANDI:    op = AND;
			ORI:     op = OR;
			XORI:    op = XOR;
			ADDI:    op = ADD;
			ADDUI:   op = ADD;
			SUBI:    op = SUB;
			CMPI:    op = CMP;
			MOVI:    op = MOV;
			LUI:     op = PASSUPPER;
			default: aluValid = 1'b0; // MEM group and unused opcodes
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Control word
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		ctrl            = '0;
		ctrl.aluOp      = op;
		ctrl.useImm     = !(instIn.opcode inside {REG, MEM});
		// Logical immediates and addui are unsigned
		ctrl.zeroExtend = instIn.opcode inside {ANDI, ORI, XORI, ADDUI};

		// Memory and jump ops share the MEM opcode
		ctrl.memRead    = isMem && (instIn.opExt == `EXT_LOAD);
		ctrl.memWrite   = isMem && (instIn.opExt == `EXT_STOR);
		ctrl.isJump     = isMem && (instIn.opExt == `EXT_JCOND);
		ctrl.jumpCond   = jumpCond_e'(instIn.rDest);

		// Compares touch flags only
		ctrl.regWrite   = (aluValid && (op != CMP)) || ctrl.memRead;
		ctrl.flagWrite  = aluValid && (op inside {ADD, SUB, CMP});
	end

	// Immediate extension
	always_comb
	begin
		if (ctrl.zeroExtend)
			imm = {{(`DATA_W - `IMM_W){1'b0}}, immRaw};
		else
			imm = {{(`DATA_W - `IMM_W){immRaw[`IMM_W-1]}}, immRaw}; // Sign copy
	end

endmodule

// ==== hdl/regFile.sv ====
`include "cpu_consts.svh"

module regFile
(
	input  logic               CLK,
	input  logic               rstN,
	input  logic [`REG_AW-1:0] rAddrA,  // rDest side
	input  logic [`REG_AW-1:0] rAddrB,  // rSrc side
	output logic [`DATA_W-1:0] rDataA,
	output logic [`DATA_W-1:0] rDataB,
	input  logic               wEn,
	input  logic [`REG_AW-1:0] wAddr,
	input  logic [`DATA_W-1:0] wData
);

	logic [`DATA_W-1:0] regs [`REG_COUNT];

	// Asynchronous reads
	assign rDataA = regs[rAddrA];
	assign rDataB = regs[rAddrB];

	// Single write port, new value seen by the next instruction
	always_ff @(posedge CLK)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (wEn)
		begin
			regs[wAddr] <= wData;
		end
	end

endmodule

// ==== hdl/alu.sv ====
`include "cpu_consts.svh"

module alu import cpu_pkg::*;
(
	input  logic               CLK,
	input  logic               rstN,
	input  decodeCtrl_t        ctrl,
	input  logic [`DATA_W-1:0] opA,    // register[rDest]
	input  logic [`DATA_W-1:0] opB,    // immediate or register[rSrc]
	output logic [`DATA_W-1:0] result,
	output flags_t             flags
);

	localparam int MSB = `DATA_W - 1;

	logic [`DATA_W:0]   sum;     // Extra bit is carry out
	logic [`DATA_W:0]   diff;    // Extra bit is borrow
	logic               addOvf;
	logic               subOvf;
	logic [`FLAG_W-1:0] flagReg;
	flags_t             nextFlags;

	assign sum  = {1'b0, opA} + {1'b0, opB};
	assign diff = {1'b0, opA} - {1'b0, opB};

	// Signed overflow from operand and result signs
	assign addOvf = (opA[MSB] == opB[MSB]) && (sum[MSB] != opA[MSB]);
	assign subOvf = (opA[MSB] != opB[MSB]) && (diff[MSB] != opA[MSB]);

	//////////////////////////////////////////////////////////////////////
	// Result
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (ctrl.aluOp)
			AND:       result = opA & opB;
			OR:        result = opA | opB;
			XOR:       result = opA ^ opB;
			ADD:       result = sum[MSB:0];
			SUB, CMP:  result = diff[MSB:0];
			MOV:       result = opB;
			PASSUPPER: result = {opB[`IMM_W-1:0], opA[`IMM_W-1:0]}; // lui keeps low byte
			default:   result = opA & opB;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Flags
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		nextFlags = flagReg; // Untouched bits hold
		case (ctrl.aluOp)
			ADD:
			begin
				nextFlags.carry    = sum[`DATA_W];
				nextFlags.overflow = addOvf;
			end
			SUB:
			begin
				nextFlags.carry    = diff[`DATA_W];
				nextFlags.overflow = subOvf;
			end
			CMP:
			begin
				nextFlags.low      = opA < opB;
				nextFlags.negative = $signed(opA) < $signed(opB);
				nextFlags.zero     = opA == opB;
			end
			default: ;
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (!rstN)
			flagReg <= '0;
		else if (ctrl.flagWrite)
			flagReg <= nextFlags;
	end

	assign flags = flagReg;

endmodule

// ==== hdl/jumpUnit.sv ====
module jumpUnit import cpu_pkg::*;
(
	input  decodeCtrl_t ctrl,
	input  flags_t      flags,       // Stored flags, not this cycle's
	output logic        pcInc,
	output logic        jAddrSelect
);

	logic condMet;

	// Condition test against the last compare
	always_comb
	begin
		case (ctrl.jumpCond)
			EQ:      condMet = flags.zero;
			NE:      condMet = !flags.zero;
			LT:      condMet = flags.negative;
			GT:      condMet = !flags.negative && !flags.zero;
			UC:      condMet = 1'b1;
			default: condMet = 1'b0; // Unsupported code never jumps
		endcase
	end

	assign jAddrSelect = ctrl.isJump && condMet;
	assign pcInc       = !jAddrSelect; // Sequencer steps unless jumping

endmodule

// ==== hdl/cpuCore.sv ====
`include "cpu_consts.svh"

module cpuCore import cpu_pkg::*;
(
	input  logic               CLK,
	input  logic               rstN,
	input  logic [`DATA_W-1:0] inst,
	input  logic [`DATA_W-1:0] externalDin, // Load data
	output logic               w1,
	output logic [`DATA_W-1:0] addr1,
	output logic [`DATA_W-1:0] data1,
	output flags_t             flags,
	output logic [`DATA_W-1:0] B,
	output logic [`DATA_W-1:0] aluOut,
	output logic               pcInc,
	output logic               jAddrSelect
);

	instFields_t        instWord;
	decodeCtrl_t        ctrl;
	logic [`DATA_W-1:0] imm;
	logic [`DATA_W-1:0] rDataA;
	logic [`DATA_W-1:0] rDataB;
	logic [`DATA_W-1:0] wbData;

	assign instWord = inst;

	//////////////////////////////////////////////////////////////////////
	// Decode and operands
	//////////////////////////////////////////////////////////////////////

	instDecoder i_dec (.instIn(instWord), .ctrl(ctrl), .imm(imm));

	regFile i_regs
	(
		.CLK(CLK),       .rstN(rstN),
		.rAddrA(instWord.rDest), .rAddrB(instWord.rSrc),
		.rDataA(rDataA), .rDataB(rDataB),
		.wEn(ctrl.regWrite), .wAddr(instWord.rDest), .wData(wbData)
	);

	assign B      = ctrl.useImm ? imm : rDataB;
	assign wbData = ctrl.memRead ? externalDin : aluOut; // Load bypasses ALU

	alu i_alu
	(
		.CLK(CLK), .rstN(rstN), .ctrl(ctrl),
		.opA(rDataA), .opB(B), .result(aluOut), .flags(flags)
	);

	jumpUnit i_jmp (.ctrl(ctrl), .flags(flags), .pcInc(pcInc), .jAddrSelect(jAddrSelect));

	//////////////////////////////////////////////////////////////////////
	// Memory side
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		if (ctrl.memWrite)
			addr1 = rDataA;  // stor address in rDest
		else if (ctrl.memRead || ctrl.isJump)
			addr1 = rDataB;  // Load address or jump target
		else
			addr1 = '0;
	end

	assign data1 = ctrl.memWrite ? rDataB : aluOut;
	assign w1    = ctrl.memWrite;

endmodule

// ==== test/cpuCore_assert.sv ====
module cpuCore_assert import cpu_pkg::*;
(
	input logic   CLK,
	input logic   rstN,
	input logic   w1,
	input logic   jAddrSelect,
	input logic   pcInc,
	input flags_t flags
);

	int failCount = 0; // Failed assertion count

	// A store and a jump never share a cycle
	noStoreJump: assert property (@(posedge CLK) disable iff (!rstN) !(w1 && jAddrSelect))
		else
		begin
			failCount++;
			$error("w1 and jAddrSelect both high");
		end

	pcIncInverse: assert property (@(posedge CLK) disable iff (!rstN) pcInc == !jAddrSelect)
		else
		begin
			failCount++;
			$error("pcInc is not the inverse of jAddrSelect");
		end

	// Flag register cleared by reset
	flagsCleared: assert property (@(posedge CLK) !rstN |=> flags == '0)
		else
		begin
			failCount++;
			$error("flags not zero after reset");
		end

endmodule

bind cpuCore cpuCore_assert i_assert
(
	.CLK(CLK), .rstN(rstN), .w1(w1), .jAddrSelect(jAddrSelect),
	.pcInc(pcInc), .flags(flags)
);

// ==== test/cpuCore_tb.sv ====
`include "cpu_consts.svh"

module cpuCore_tb import cpu_pkg::*;
();

	localparam int RESET_CYCLES   = 5;
	localparam int DIRECTED_COUNT = 15;
	localparam int RANDOM_COUNT   = 400;
	// Margin over the whole run length
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + DIRECTED_COUNT + RANDOM_COUNT + 180;
	localparam logic [31:0] LFSR_SEED = 32'hb42a_1e65;
	localparam logic [31:0] LFSR_POLY = 32'h8020_0003; // Taps 32, 22, 2, 1

	// Stimulus tables limited to the listed encodings
	localparam opcode_e OPCODES [11] = '{REG, ANDI, ORI, XORI, MEM, ADDI, ADDUI, SUBI, CMPI,
		MOVI, LUI};
	localparam logic [3:0] REG_EXTS [7] = '{`EXT_AND, `EXT_OR, `EXT_XOR, `EXT_ADD, `EXT_SUB,
		`EXT_CMP, `EXT_MOV};
	localparam logic [3:0] MEM_EXTS [3] = '{`EXT_LOAD, `EXT_STOR, `EXT_JCOND};
	localparam logic [3:0] CONDS [5]    = '{EQ, NE, LT, GT, UC};

	logic               CLK;
	logic               rstN;
	logic [`DATA_W-1:0] inst;
	logic [`DATA_W-1:0] externalDin;
	logic               w1;
	logic [`DATA_W-1:0] addr1;
	logic [`DATA_W-1:0] data1;
	flags_t             flags;
	logic [`DATA_W-1:0] B;
	logic [`DATA_W-1:0] aluOut;
	logic               pcInc;
	logic               jAddrSelect;

	logic [`DATA_W-1:0] modelRegs [`REG_COUNT]; // Reference register file
	flags_t             modelFlags;
	logic [31:0]        lfsrState = LFSR_SEED;
	int                 checkCount = 0;
	int                 errorCount = 0;
	int                 cycleCount;

	cpuCore i_dut
	(
		.CLK(CLK), .rstN(rstN), .inst(inst), .externalDin(externalDin),
		.w1(w1), .addr1(addr1), .data1(data1), .flags(flags), .B(B),
		.aluOut(aluOut), .pcInc(pcInc), .jAddrSelect(jAddrSelect)
	);

	initial
	begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	//////////////////////////////////////////////////////////////////////
	// Random source
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_POLY) : (s >> 1);
	endfunction

	// One LFSR step per bit
	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			bits      = {bits[30:0], lfsrState[0]};
			lfsrState = lfsrNext(lfsrState);
		end
		return bits;
	endfunction

	task automatic randomInst(output logic [`DATA_W-1:0] word, output logic [`DATA_W-1:0] din);
		instFields_t f;
		f.rDest  = 4'(takeBits(4));
		f.rSrc   = 4'(takeBits(4));
		f.opExt  = 4'(takeBits(4)); // High immediate nibble
		f.opcode = OPCODES[int'(takeBits(4)) % 11];
		if (f.opcode == REG)
			f.opExt = REG_EXTS[int'(takeBits(3)) % 7];
		else if (f.opcode == MEM)
		begin
			f.opExt = MEM_EXTS[int'(takeBits(2)) % 3];
			if (f.opExt == `EXT_JCOND)
				f.rDest = CONDS[int'(takeBits(3)) % 5]; // Condition code field
		end
		word = f;
		din  = 16'(takeBits(16));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Checking and reference model
	//////////////////////////////////////////////////////////////////////

	task automatic checkValue(input logic [15:0] got, input logic [15:0] expected,
		input string what);
		checkCount++;
		if (got !== expected)
		begin
			errorCount++;
			$display("FAILED at %0t: %s expected %h got %h", $time, what, expected, got);
		end
	endtask

	// Compare this cycle's outputs, then commit what the next edge writes
	task automatic checkAndStep(input logic [15:0] word, input logic [15:0] din);
		instFields_t f;
		logic [15:0] rD, rS, immS, immZ, opB, res, expAddr;
		aluOp_e      kind;
		logic        isAlu, wrAlu, isLoad, isStor, isJump, taken;
		flags_t      nf;
		int          wide, sWide;
		f     = word;
		rD    = modelRegs[f.rDest];
		rS    = modelRegs[f.rSrc];
		immZ  = {8'h00, f.opExt, f.rSrc};
		immS  = {{8{f.opExt[3]}}, f.opExt, f.rSrc};
		opB   = immS;
		kind  = AND;
		isAlu = 1'b1;
		wrAlu = 1'b1;
		{isLoad, isStor, isJump, taken} = '0;
		nf    = modelFlags;
		res   = '0;
		case (f.opcode)
			REG:
			begin
				opB = rS;
				case (f.opExt)
					`EXT_AND: kind = AND;
					`EXT_OR:  kind = OR;
					`EXT_XOR: kind = XOR;
					`EXT_ADD: kind = ADD;
					`EXT_SUB: kind = SUB;
					`EXT_CMP: kind = CMP;
					`EXT_MOV: kind = MOV;
					default:  wrAlu = 1'b0; // Unused ext is a nop
				endcase
			end
			ANDI:
			begin
				opB  = immZ;
				kind = AND;
			end
			ORI:
			begin
				opB  = immZ;
				kind = OR;
			end
			XORI:
			begin
				opB  = immZ;
				kind = XOR;
			end
			ADDI:  kind = ADD;
			ADDUI:
			begin
				opB  = immZ;
				kind = ADD;
			end
			SUBI:  kind = SUB;
			CMPI:  kind = CMP;
			MOVI:  kind = MOV;
			LUI:   kind = PASSUPPER;
			MEM:
			begin
				opB    = rS;
				isAlu  = 1'b0;
				isLoad = f.opExt == `EXT_LOAD;
				isStor = f.opExt == `EXT_STOR;
				isJump = f.opExt == `EXT_JCOND;
			end
			default: isAlu = 1'b0; // Never generated
		endcase

		if (isAlu)
		begin
			case (kind)
				AND: res = rD & opB;
				OR:  res = rD | opB;
				XOR: res = rD ^ opB;
				ADD:
				begin
					res         = rD + opB;
					wide        = int'(rD) + int'(opB);
					sWide       = int'($signed(rD)) + int'($signed(opB));
					nf.carry    = wide > 65535;
					nf.overflow = (sWide > 32767) || (sWide < -32768);
				end
				SUB:
				begin
					res         = rD - opB;
					sWide       = int'($signed(rD)) - int'($signed(opB));
					nf.carry    = rD < opB; // Borrow
					nf.overflow = (sWide > 32767) || (sWide < -32768);
				end
				CMP:
				begin
					res         = rD - opB;
					nf.low      = rD < opB;
					nf.negative = $signed(rD) < $signed(opB);
					nf.zero     = rD == opB;
					wrAlu       = 1'b0;
				end
				MOV:     res = opB;
				default: res = {opB[7:0], rD[7:0]}; // lui
			endcase
		end

		if (isJump)
		begin
			case (jumpCond_e'(f.rDest))
				EQ:      taken = modelFlags.zero;
				NE:      taken = !modelFlags.zero;
				LT:      taken = modelFlags.negative;
				GT:      taken = !modelFlags.negative && !modelFlags.zero;
				UC:      taken = 1'b1;
				default: taken = 1'b0;
			endcase
		end
		expAddr = isStor ? rD : ((isLoad || isJump) ? rS : '0);

		checkValue(addr1, expAddr, "addr1");
		checkValue(16'(w1), 16'(isStor), "w1");
		checkValue(B, opB, "B");
		checkValue(16'(jAddrSelect), 16'(taken), "jAddrSelect");
		checkValue(16'(pcInc), 16'(!taken), "pcInc");
		checkValue(16'(flags), 16'(modelFlags), "flags");
		if (isAlu)
		begin
			checkValue(aluOut, res, "aluOut");
			checkValue(data1, res, "data1");
		end
		if (isStor)
			checkValue(data1, rS, "stor data1");

		if (isAlu && wrAlu)
			modelRegs[f.rDest] = res;
		if (isLoad)
			modelRegs[f.rDest] = din;
		modelFlags = nf;
	endtask

	// Drive at the rising edge, check at the falling edge
	task automatic runInst(input logic [15:0] word, input logic [15:0] din);
		@(posedge CLK);
		inst        <= word;
		externalDin <= din;
		@(negedge CLK);
		checkAndStep(word, din);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed sequence
	//////////////////////////////////////////////////////////////////////

	task automatic directedSeq();
		runInst(16'h0000, 16'h0000); // and r0,r0 after reset
		checkValue(data1, 16'h0000, "data1 after reset");
		runInst(16'h61FF, 16'h0000); // addui r1,255
		checkValue(aluOut, 16'h00FF, "addui 255");
		runInst(16'hF212, 16'h0000); // lui r2,0x12
		runInst(16'h2234, 16'h0000); // ori r2,0x34
		runInst(16'h03D2, 16'h0000); // mov r3,r2
		checkValue(aluOut, 16'h1234, "lui/ori constant");
		runInst(16'h0333, 16'h0000); // xor r3,r3
		checkValue(aluOut, 16'h0000, "xor self");
		runInst(16'hB1FF, 16'h0000); // cmpi r1,-1 sets low only
		runInst(16'h0112, 16'h0000); // and r1,r2 keeps flags
		checkValue(16'(flags), 16'(flags_t'(5'b01000)), "flags after cmpi");
		runInst(16'h46C2, 16'h0000); // jlt r2, not taken
		runInst(16'h41C2, 16'h0000); // jne r2, taken
		checkValue(16'(jAddrSelect), 16'h0001, "jne taken");
		runInst(16'h4241, 16'h0000); // stor r1 to [r2]
		checkValue(16'(w1), 16'h0001, "stor w1");
		runInst(16'h4502, 16'hBEEF); // load r5 from [r2]
		runInst(16'h06D5, 16'h0000); // mov r6,r5
		checkValue(aluOut, 16'hBEEF, "load write-back");
		runInst(16'h06B6, 16'h0000); // cmp r6,r6
		runInst(16'h40C5, 16'h0000); // jeq r5, taken
		checkValue(16'(jAddrSelect), 16'h0001, "jeq taken");
	endtask

	initial
	begin
		logic [15:0] word;
		logic [15:0] din;
		rstN        = 1'b0;
		inst        = '0;
		externalDin = '0;
		modelFlags  = '0;
		for (int i = 0; i < `REG_COUNT; i++)
			modelRegs[i] = '0;
		repeat (RESET_CYCLES) @(posedge CLK);
		rstN <= 1'b1;

		directedSeq();
		for (int n = 0; n < RANDOM_COUNT; n++)
		begin
			randomInst(word, din);
			runInst(word, din);
		end

		errorCount += i_dut.i_assert.failCount; // Bound assertion failures
		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// Watchdog
	initial
	begin
		cycleCount = 0;
		while (cycleCount < TIMEOUT_CYCLES)
		begin
			@(posedge CLK);
			cycleCount++;
		end
		$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("tests failed");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+include
hdl/cpu_pkg.sv
hdl/instDecoder.sv
hdl/regFile.sv
hdl/alu.sv
hdl/jumpUnit.sv
hdl/cpuCore.sv
test/cpuCore_assert.sv
test/cpuCore_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = cpuCore_tb
FLIST      = flist.f
OBJ_DIR    = obj_dir
PASS_MSG   = all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
